//--- rv_stim.txt
# P name | I instruction word in hex
# R pc rd we data in hex, data not checked when we is 0 | E halt or invalid
P alu_imm
I ffb00093
I 0030a113
I 0030b193
I 0f00c213
I 00c26293
I 7ff2f313
I 00431393
I 01c0d413
I 4010d493
I 00100073
R 80000000 01 1 fffffffb
R 80000004 02 1 00000001
R 80000008 03 1 00000000
R 8000000c 04 1 ffffff0b
R 80000010 05 1 ffffff0f
R 80000014 06 1 0000070f
R 80000018 07 1 000070f0
R 8000001c 08 1 0000000f
R 80000020 09 1 fffffffd
R 80000024 00 0 00000000
E halt
P alu_reg
I ff800093
I 00300113
I 401101b3
I 4020d233
I 0040b2b3
I 0020a333
I 005183b3
I 00239433
I 0020d4b3
I 0044c533
I 008565b3
I 0015f633
I 00100073
R 80000000 01 1 fffffff8
R 80000004 02 1 00000003
R 80000008 03 1 0000000b
R 8000000c 04 1 ffffffff
R 80000010 05 1 00000001
R 80000014 06 1 00000001
R 80000018 07 1 0000000c
R 8000001c 08 1 00000060
R 80000020 09 1 1fffffff
R 80000024 0a 1 e0000000
R 80000028 0b 1 e0000060
R 8000002c 0c 1 e0000060
R 80000030 00 0 00000000
E halt
P upper_x0
I 123450b7
I 00010117
I 12308013
I 000001b3
I 00100073
R 80000000 01 1 12345000
R 80000004 02 1 80010004
R 80000008 00 1 12345123
R 8000000c 03 1 00000000
R 80000010 00 0 00000000
E halt
P invalid_load
I 00700093
I 0080a283
I 00100313
I 00100073
R 80000000 01 1 00000007
R 80000004 05 0 00000000
E invalid

//--- src.f
rv_pkg.sv
stage_if.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_core_top.sv
rv_core_assert.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then judge the simulation log
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module tb_rv_core -f src.f > build.log 2>&1 ||
	{ cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_rv_core > sim.log 2>&1 ; cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0

//--- tb_rv_core.sv
module tb_rv_core;
	import rv_pkg::*;

	logic        clk;
	logic        rst = 1'b0;
	logic        imem_req;
	word_t       imem_addr;
	logic        imem_ack = 1'b0;
	word_t       imem_rdata = '0;
	logic        retire_valid;
	word_t       retire_pc;
	reg_addr_t   retire_rd;
	logic        retire_we;
	word_t       retire_data;
	logic        halt;
	logic        invalid;

	// one entry per program in the stim file
	string       prog_name[$];
	int          prog_inst_base[$];
	int          prog_inst_cnt[$];
	int          prog_ret_base[$];
	int          prog_ret_cnt[$];
	logic        prog_halt[$];

	// flat storage shared by all programs
	word_t       inst_words[$];
	word_t       ret_pc[$];
	reg_addr_t   ret_rd[$];
	logic        ret_we[$];
	word_t       ret_data[$];

	// program currently served by the memory model
	string       cur_name = "";
	int          cur_base = 0;
	int          cur_cnt = 0;

	int          seed = 32'hb89e_5a4e;
	int          delay_left = -1;
	int          wait_now = 0;
	logic [31:0] draw;
	int          cycles = 0;
	int          limit = 0;
	int          p;

	rv_core_top u_rv_core_top (
		.clk            (clk),
		.rst            (rst),
		.imem_req_o     (imem_req),
		.imem_addr_o    (imem_addr),
		.imem_ack_i     (imem_ack),
		.imem_rdata_i   (imem_rdata),
		.retire_valid_o (retire_valid),
		.retire_pc_o    (retire_pc),
		.retire_rd_o    (retire_rd),
		.retire_we_o    (retire_we),
		.retire_data_o  (retire_data),
		.halt_o         (halt),
		.invalid_o      (invalid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	// word index relative to the reset pc
	function automatic word_t fetch_word(input word_t addr);
		word_t off;
		int    idx;
		off = addr - RESET_PC;
		idx = int'(off >> 2);
		if (idx < cur_cnt) begin
			return inst_words[cur_base + idx];
		end else begin
			// prefetch past the end that decode drops
			return '0;
		end
	endfunction

	// four-phase responder with 0 to 3 idle cycles before ack
	always @(posedge clk) begin
		if (!rst) begin
			imem_ack   <= 1'b0;
			delay_left <= -1;
		end else if (imem_ack) begin
			// ack stays up until req falls
			if (!imem_req) begin
				imem_ack <= 1'b0;
			end
		end else if (imem_req) begin
			// wait drawn once when the request is first seen
			if (delay_left < 0) begin
				draw     = $random(seed);
				wait_now = {30'b0, draw[1:0]};
			end else begin
				wait_now = delay_left;
			end
			if (wait_now == 0) begin
				imem_ack   <= 1'b1;
				imem_rdata <= fetch_word(imem_addr);
				delay_left <= -1;
			end else begin
				delay_left <= wait_now - 1;
			end
		end
	end

	// run watchdog armed once the limit is known
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			fail_now($sformatf("timeout, run did not finish within %0d cycles", limit));
		end
	end

	task automatic load_stim;
		int          fd;
		int          code;
		int          cur;
		string       line;
		string       text;
		byte         kind;
		logic [31:0] f_pc;
		logic [31:0] f_rd;
		logic [31:0] f_we;
		logic [31:0] f_data;
		fd = $fopen("rv_stim.txt", "r");
		if (fd == 0) begin
			fail_now("could not open the stim file rv_stim.txt");
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2) begin
				continue;
			end
			kind = line.getc(0);
			cur = prog_name.size() - 1;
			if (kind != "P" && kind != "#" && cur < 0) begin
				fail_now("stim file has a record before the first program line");
			end
			case (kind)
				"P": begin
					code = $sscanf(line, "P %s", text);
					prog_name.push_back(text);
					prog_inst_base.push_back(inst_words.size());
					prog_inst_cnt.push_back(0);
					prog_ret_base.push_back(ret_pc.size());
					prog_ret_cnt.push_back(0);
					prog_halt.push_back(1'b1);
				end
				"I": begin
					code = $sscanf(line, "I %h", f_data);
					inst_words.push_back(f_data);
					prog_inst_cnt[cur] = prog_inst_cnt[cur] + 1;
				end
				"R": begin
					code = $sscanf(line, "R %h %h %h %h", f_pc, f_rd, f_we, f_data);
					ret_pc.push_back(f_pc);
					ret_rd.push_back(f_rd[4:0]);
					ret_we.push_back(f_we[0]);
					ret_data.push_back(f_data);
					prog_ret_cnt[cur] = prog_ret_cnt[cur] + 1;
				end
				"E": begin
					code = $sscanf(line, "E %s", text);
					prog_halt[cur] = (text == "halt");
				end
				default: begin
					// comment line
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic check_word(input string field, input word_t exp, input word_t act);
		if (act !== exp) begin
			fail_now($sformatf("[ERROR] %s %s expected %h actual %h", cur_name, field, exp, act));
		end
	endtask

	task automatic check_reg(input string field, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp) begin
			fail_now($sformatf("[ERROR] %s %s expected %h actual %h", cur_name, field, exp, act));
		end
	endtask

	task automatic check_flag(input string field, input logic exp, input logic act);
		if (act !== exp) begin
			fail_now($sformatf("[ERROR] %s %s expected %b actual %b", cur_name, field, exp, act));
		end
	endtask

	task automatic check_retire(input int r);
		check_word("retire pc", ret_pc[r], retire_pc);
		check_reg("retire rd", ret_rd[r], retire_rd);
		check_flag("retire we", ret_we[r], retire_we);
		// data only defined when the register is written
		if (ret_we[r]) begin
			check_word("retire data", ret_data[r], retire_data);
		end
	endtask

	task automatic apply_reset;
		@(posedge clk);
		rst <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic run_program(input int idx);
		int r;
		cur_name = prog_name[idx];
		cur_base = prog_inst_base[idx];
		cur_cnt  = prog_inst_cnt[idx];
		apply_reset();
		// outputs settle by the falling edge
		for (r = 0; r < prog_ret_cnt[idx]; r++) begin
			@(negedge clk);
			while (!retire_valid) begin
				@(negedge clk);
			end
			check_retire(prog_ret_base[idx] + r);
		end
		check_flag("halt_o", prog_halt[idx], halt);
		check_flag("invalid_o", !prog_halt[idx], invalid);
		// stopped core must stay quiet
		repeat (12) begin
			@(negedge clk);
			if (retire_valid) begin
				fail_now($sformatf("%s: an instruction retired after the core stopped",
					cur_name));
			end
		end
	endtask

	initial begin
		load_stim();
		if (prog_name.size() == 0) begin
			fail_now("stim file holds no program");
		end
		// 20 cycles per instruction plus 20 per program
		limit = 20 * inst_words.size() + 20 * prog_name.size();
		for (p = 0; p < prog_name.size(); p++) begin
			run_program(p);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

//--- rv_core_assert.sv
module rv_core_assert (
	input logic          clk,
	input logic          rst,
	input logic          imem_req_o,
	input rv_pkg::word_t imem_addr_o,
	input logic          imem_ack_i,
	input logic          retire_valid_o,
	input logic          halt_o,
	input logic          invalid_o
);

	// req held until memory answers
	a_req_hold: assert property (@(posedge clk) disable iff (!rst)
		(imem_req_o && !imem_ack_i) |=> imem_req_o)
		else $error("imem req dropped before ack");

	// address frozen for the whole request
	a_addr_stable: assert property (@(posedge clk) disable iff (!rst)
		imem_req_o |=> (!imem_req_o || $stable(imem_addr_o)))
		else $error("imem address moved while req high");

	// no new request until ack is gone
	a_req_after_ack: assert property (@(posedge clk) disable iff (!rst)
		(!imem_req_o && imem_ack_i) |=> !imem_req_o)
		else $error("imem req raised while ack high");

	// stopped core retires nothing more
	a_quiet_after_stop: assert property (@(posedge clk) disable iff (!rst)
		(halt_o || invalid_o) |=> !retire_valid_o)
		else $error("retire after halt or invalid");

	// sync reset clears every control output
	a_reset_state: assert property (@(posedge clk)
		!rst |=> (!imem_req_o && !retire_valid_o && !halt_o && !invalid_o))
		else $error("control output high after reset");

endmodule

bind rv_core_top rv_core_assert u_core_assert (
	.clk            (clk),
	.rst            (rst),
	.imem_req_o     (imem_req_o),
	.imem_addr_o    (imem_addr_o),
	.imem_ack_i     (imem_ack_i),
	.retire_valid_o (retire_valid_o),
	.halt_o         (halt_o),
	.invalid_o      (invalid_o)
);

//--- rv_core_top.sv
module rv_core_top (
	input  logic              clk,
	input  logic              rst,
	output logic              imem_req_o,
	output rv_pkg::word_t     imem_addr_o,
	input  logic              imem_ack_i,
	input  rv_pkg::word_t     imem_rdata_i,
	output logic              retire_valid_o,
	output rv_pkg::word_t     retire_pc_o,
	output rv_pkg::reg_addr_t retire_rd_o,
	output logic              retire_we_o,
	output rv_pkg::word_t     retire_data_o,
	output logic              halt_o,
	output logic              invalid_o
);
	import rv_pkg::*;

	// register file ports
	reg_addr_t rf_raddr1;
	reg_addr_t rf_raddr2;
	word_t     rf_rdata1;
	word_t     rf_rdata2;
	logic      rf_we;
	reg_addr_t rf_waddr;
	word_t     rf_wdata;

	// stop from decode back to fetch
	logic      stop;

	// execute to writeback
	logic      wb_valid;
	exe_pl_t   wb_rec;

	stage_if #(.payload_t(fetch_pl_t)) f2d ();
	stage_if #(.payload_t(dec_pl_t))   d2e ();

	rv_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.stop_i       (stop),
		.imem_req_o   (imem_req_o),
		.imem_addr_o  (imem_addr_o),
		.imem_ack_i   (imem_ack_i),
		.imem_rdata_i (imem_rdata_i),
		.out          (f2d.src)
	);

	rv_decode u_decode (
		.clk      (clk),
		.rst      (rst),
		.in       (f2d.dst),
		.out      (d2e.src),
		.raddr1_o (rf_raddr1),
		.raddr2_o (rf_raddr2),
		.rdata1_i (rf_rdata1),
		.rdata2_i (rf_rdata2),
		.stop_o   (stop)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.raddr1_i (rf_raddr1),
		.raddr2_i (rf_raddr2),
		.rdata1_o (rf_rdata1),
		.rdata2_o (rf_rdata2),
		.we_i     (rf_we),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata)
	);

	rv_execute u_execute (
		.clk        (clk),
		.rst        (rst),
		.in         (d2e.dst),
		.wb_valid_o (wb_valid),
		.wb_o       (wb_rec)
	);

	rv_writeback u_writeback (
		.clk            (clk),
		.rst            (rst),
		.valid_i        (wb_valid),
		.wb_i           (wb_rec),
		.reg_we_o       (rf_we),
		.reg_waddr_o    (rf_waddr),
		.reg_wdata_o    (rf_wdata),
		.retire_valid_o (retire_valid_o),
		.retire_pc_o    (retire_pc_o),
		.retire_rd_o    (retire_rd_o),
		.retire_we_o    (retire_we_o),
		.retire_data_o  (retire_data_o),
		.halt_o         (halt_o),
		.invalid_o      (invalid_o)
	);

endmodule

//--- rv_writeback.sv
module rv_writeback (
	input  logic              clk,
	input  logic              rst,
	input  logic              valid_i,
	input  rv_pkg::exe_pl_t   wb_i,
	output logic              reg_we_o,
	output rv_pkg::reg_addr_t reg_waddr_o,
	output rv_pkg::word_t     reg_wdata_o,
	output logic              retire_valid_o,
	output rv_pkg::word_t     retire_pc_o,
	output rv_pkg::reg_addr_t retire_rd_o,
	output logic              retire_we_o,
	output rv_pkg::word_t     retire_data_o,
	output logic              halt_o,
	output logic              invalid_o
);

	// regfile write straight from execute record
	assign reg_we_o    = valid_i && wb_i.we;
	assign reg_waddr_o = wb_i.rd;
	assign reg_wdata_o = wb_i.result;

	// sticky flags
	always_ff @(posedge clk) begin
		if (!rst) begin
			retire_valid_o <= 1'b0;
			halt_o         <= 1'b0;
			invalid_o      <= 1'b0;
		end else begin
			retire_valid_o <= valid_i;
			halt_o         <= halt_o | (valid_i & wb_i.halt);
			invalid_o      <= invalid_o | (valid_i & wb_i.invalid);
		end
	end

	// retire record qualified by retire_valid_o
	always_ff @(posedge clk) begin
		if (valid_i) begin
			retire_pc_o   <= wb_i.pc;
			retire_rd_o   <= wb_i.rd;
			retire_we_o   <= wb_i.we;
			retire_data_o <= wb_i.result;
		end
	end

endmodule

//--- rv_execute.sv
module rv_execute (
	input  logic            clk,
	input  logic            rst,
	stage_if.dst            in,
	output logic            wb_valid_o,
	output rv_pkg::exe_pl_t wb_o
);
	import rv_pkg::*;

	word_t      a;
	word_t      b;
	logic [4:0] shamt;
	word_t      result;

	assign a     = in.payload.opa;
	assign b     = in.payload.opb;
	// rv32 shifts use five bits
	assign shamt = b[4:0];

	// single cycle alu that never waits
	assign in.stall = 1'b0;

	always_comb begin
		case (in.payload.op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_SLL:    result = a << shamt;
			ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:   result = {31'b0, a < b};
			ALU_XOR:    result = a ^ b;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = word_t'($signed(a) >>> shamt);
			ALU_OR:     result = a | b;
			ALU_AND:    result = a & b;
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= in.valid;
		end
	end

	// record for writeback
	always_ff @(posedge clk) begin
		if (in.valid) begin
			wb_o.pc      <= in.payload.pc;
			wb_o.rd      <= in.payload.rd;
			wb_o.we      <= in.payload.we;
			wb_o.result  <= result;
			wb_o.halt    <= in.payload.halt;
			wb_o.invalid <= in.payload.invalid;
		end
	end

endmodule

//--- rv_decode.sv
module rv_decode (
	input  logic              clk,
	input  logic              rst,
	stage_if.dst              in,
	stage_if.src              out,
	output rv_pkg::reg_addr_t raddr1_o,
	output rv_pkg::reg_addr_t raddr2_o,
	input  rv_pkg::word_t     rdata1_i,
	input  rv_pkg::word_t     rdata2_i,
	output logic              stop_o
);
	import rv_pkg::*;

	word_t      inst;
	word_t      imm_i;
	word_t      imm_u;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       use_rs1;
	logic       use_rs2;
	logic       hazard;
	logic       advance;
	logic       load;
	logic       stop_q;
	dec_pl_t    dec;

	// instruction fields
	assign inst     = in.payload.inst;
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign imm_i    = {{20{inst[31]}}, inst[31:20]};
	assign imm_u    = {inst[31:12], 12'b0};
	assign raddr1_o = inst[19:15];
	assign raddr2_o = inst[24:20];

	always_comb begin
		dec.pc      = in.payload.pc;
		dec.opa     = rdata1_i;
		dec.opb     = imm_i;
		dec.op      = ALU_ADD;
		dec.rd      = inst[11:7];
		dec.we      = 1'b1;
		dec.halt    = 1'b0;
		dec.invalid = 1'b0;
		use_rs1     = 1'b0;
		use_rs2     = 1'b0;
		case (inst[6:0])
			OPC_LUI: begin
				dec.opb = imm_u;
				dec.op  = ALU_PASS_B;
			end
			// pc plus upper immediate
			OPC_AUIPC: begin
				dec.opa = in.payload.pc;
				dec.opb = imm_u;
			end
			OPC_OP_IMM: begin
				use_rs1 = 1'b1;
				case (funct3)
					3'b010: dec.op = ALU_SLT;
					3'b011: dec.op = ALU_SLTU;
					3'b100: dec.op = ALU_XOR;
					3'b110: dec.op = ALU_OR;
					3'b111: dec.op = ALU_AND;
					3'b001: begin
						dec.op      = ALU_SLL;
						dec.invalid = (funct7 != 7'b0000000);
					end
					// srli or srai by bit 30
					3'b101: begin
						dec.op      = funct7[5] ? ALU_SRA : ALU_SRL;
						dec.invalid = ({funct7[6], funct7[4:0]} != 6'b0);
					end
					default: dec.op = ALU_ADD;
				endcase
			end
			OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				dec.opb = rdata2_i;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec.op = ALU_ADD;
					{7'b0100000, 3'b000}: dec.op = ALU_SUB;
					{7'b0000000, 3'b001}: dec.op = ALU_SLL;
					{7'b0000000, 3'b010}: dec.op = ALU_SLT;
					{7'b0000000, 3'b011}: dec.op = ALU_SLTU;
					{7'b0000000, 3'b100}: dec.op = ALU_XOR;
					{7'b0000000, 3'b101}: dec.op = ALU_SRL;
					{7'b0100000, 3'b101}: dec.op = ALU_SRA;
					{7'b0000000, 3'b110}: dec.op = ALU_OR;
					{7'b0000000, 3'b111}: dec.op = ALU_AND;
					default: dec.invalid = 1'b1;
				endcase
			end
			// only ebreak survives in system space
			OPC_SYSTEM: begin
				dec.halt    = (inst == EBREAK_INST);
				dec.invalid = (inst != EBREAK_INST);
			end
			default: dec.invalid = 1'b1;
		endcase
		// flagged words never write
		if (dec.halt || dec.invalid) begin
			dec.we = 1'b0;
		end
	end

	// source matches the write still sitting in d2e
	assign hazard = out.valid && out.payload.we && (out.payload.rd != 5'd0) &&
		((use_rs1 && raddr1_o == out.payload.rd) || (use_rs2 && raddr2_o == out.payload.rd));

	assign advance  = !out.valid || !out.stall;
	// once stopped every word is swallowed
	assign in.stall = in.valid && !stop_q && (hazard || !advance);
	assign load     = in.valid && !in.stall && !stop_q;
	assign stop_o   = stop_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			out.valid <= 1'b0;
			stop_q    <= 1'b0;
		end else begin
			// bubble on interlock
			if (advance) begin
				out.valid <= load;
			end
			if (load && (dec.halt || dec.invalid)) begin
				stop_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out.payload <= dec;
		end
	end

endmodule

//--- rv_regfile.sv
module rv_regfile (
	input  logic              clk,
	input  logic              rst,
	input  rv_pkg::reg_addr_t raddr1_i,
	input  rv_pkg::reg_addr_t raddr2_i,
	output rv_pkg::word_t     rdata1_o,
	output rv_pkg::word_t     rdata2_o,
	input  logic              we_i,
	input  rv_pkg::reg_addr_t waddr_i,
	input  rv_pkg::word_t     wdata_i
);
	import rv_pkg::*;

	word_t regs [32];
	logic  wr_live;

	// x0 never takes a write
	assign wr_live = we_i && (waddr_i != 5'd0);

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// bypass the word being written this cycle
	assign rdata1_o = (raddr1_i == 5'd0) ? '0 :
		(wr_live && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? '0 :
		(wr_live && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

//--- rv_fetch.sv
module rv_fetch (
	input  logic          clk,
	input  logic          rst,
	input  logic          stop_i,
	output logic          imem_req_o,
	output rv_pkg::word_t imem_addr_o,
	input  logic          imem_ack_i,
	input  rv_pkg::word_t imem_rdata_i,
	stage_if.src          out
);
	import rv_pkg::*;

	typedef enum logic {
		S_IDLE,
		S_REQ
	} state_e;

	state_e state;
	word_t  pc;
	logic   room;
	logic   start;
	logic   capture;

	// output register empty or handed to decode this edge
	assign room = !out.valid || !out.stall;
	// next request only once memory has dropped ack
	assign start = !stop_i && !imem_ack_i && room;
	// word arrives with ack while req is up
	assign capture = (state == S_REQ) && imem_ack_i;

	// req comes straight from the state register
	assign imem_req_o  = (state == S_REQ);
	// pc only moves after req is dropped
	assign imem_addr_o = pc;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= S_IDLE;
			pc    <= RESET_PC;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_REQ;
					end
				end
				S_REQ: begin
					// drop req and step to next word
					if (imem_ack_i) begin
						state <= S_IDLE;
						pc    <= pc + 32'd4;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// valid stays up until decode takes the word
	always_ff @(posedge clk) begin
		if (!rst) begin
			out.valid <= 1'b0;
		end else if (capture) begin
			out.valid <= 1'b1;
		end else if (!out.stall) begin
			out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			out.payload.pc   <= pc;
			out.payload.inst <= imem_rdata_i;
		end
	end

endmodule

//--- stage_if.sv
interface stage_if #(
	parameter type payload_t = logic
);

	// transfer on a clock edge with valid high and stall low
	logic     valid;
	logic     stall;
	payload_t payload;

	// producer holds valid and payload while stalled
	modport src (
		output valid,
		output payload,
		input  stall
	);

	// consumer only pushes back
	modport dst (
		input  valid,
		input  payload,
		output stall
	);

endinterface

//--- rv_pkg.sv
package rv_pkg;

	// basic datapath types
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// alu operations with pass_b for lui
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	// fetch to decode
	typedef struct packed {
		word_t pc;
		word_t inst;
	} fetch_pl_t;

	// decode to execute
	typedef struct packed {
		word_t     pc;
		word_t     opa;
		word_t     opb;
		alu_op_e   op;
		reg_addr_t rd;
		logic      we;
		logic      halt;
		logic      invalid;
	} dec_pl_t;

	// execute to writeback
	typedef struct packed {
		word_t     pc;
		reg_addr_t rd;
		logic      we;
		word_t     result;
		logic      halt;
		logic      invalid;
	} exe_pl_t;

	localparam word_t RESET_PC = 32'h8000_0000;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam word_t EBREAK_INST = 32'h0010_0073;

endpackage
